//--- sprite_renderer_top.f
logic/sprite_pkg.sv
logic/entity_regs.sv
logic/scan_timing.sv
logic/entity_detect.sv
logic/sprite_rom.sv
logic/sprite_renderer_top.sv
verification/tb_sprite_renderer_top.sv

//--- Bender.yml
package:
  name: sprite_renderer

sources:
  - logic/sprite_pkg.sv
  - logic/entity_regs.sv
  - logic/scan_timing.sv
  - logic/entity_detect.sv
  - logic/sprite_rom.sv
  - logic/sprite_renderer_top.sv
  - target: simulation
    files:
      - verification/tb_sprite_renderer_top.sv

//--- logic/sprite_rom.mem
// one bitmap row per line, leftmost digit is column 0 (bit 7), 1 is white
// sprite n occupies lines 8n to 8n+7, top row first
01111110
01000000
01000000
01111100
01000000
01000000
01000000
00000000
01000000
01000000
01000000
01000000
01000000
01000000
01111110
00000000
01111100
01000010
01000010
01111100
01000000
01000000
01000000
00000000
01111100
01000010
01000010
01111100
01001000
01000100
01000010
00000000
10000000
11000000
11100000
11110000
11111000
11111100
11111110
11111111
00000010
00000010
00000010
00000010
01000010
01000010
00111100
00000000
11110000
11110000
11110000
11110000
00001111
00001111
00001111
00001100
11111110
00000110
00001100
00011000
00110000
01100000
11000000
10000000

//--- verification/tb_sprite_renderer_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_renderer_top;

    import sprite_pkg::*;

    localparam int clk_period = 20;
    localparam int frame_cycles = h_total * v_total;
    // last pixel of line 479
    localparam int vis_end = v_visible * h_total - 1;
    localparam int bus_timeout = 16;
    localparam int bus_budget = 4000;
    // reset frame, scene, priority, update, sync frame plus alignment gaps
    localparam int frames_run = 6;
    localparam int timeout_ns = (frames_run * frame_cycles + bus_budget) * clk_period;
    localparam int max_shown = 10;
    // id 15, orientation up, tile 0
    localparam logic [15:0] slot_reset_word = 16'h3c00;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic        wb_ack;
    logic        colour;
    logic        hsync;
    logic        vsync;
    logic        video_on;

    // reference copies of rom and slots
    logic [7:0]  rom_model [64];
    logic [13:0] model_slots [9];
    logic [15:0] bus_data [16];
    // model scan position already delayed by the pipe
    int          pos;
    int          seed;
    int          slot;
    int          base_id;
    logic [7:0]  prio_tile;
    string       test_name;
    int          test_errors;
    int          test_checks;
    int          total_errors;
    int          total_checks;
    int          tests_run;
    int          tests_failed;

    sprite_renderer_top u_sprite_renderer_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .colour   (colour),
        .hsync    (hsync),
        .vsync    (vsync),
        .video_on (video_on)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // reset parks the model two pixels before frame start
    always @(posedge clk) begin
        if (!rst_n) begin
            pos <= frame_cycles - pipe_latency;
        end else if (pos == frame_cycles - 1) begin
            pos <= 0;
        end else begin
            pos <= pos + 1;
        end
    end

    task automatic expect_val(input string sig, input logic [15:0] exp, input logic [15:0] act);
        test_checks++;
        assert (act === exp) else begin
            test_errors++;
            if (test_errors <= max_shown) begin
                $display("FAIL t=%0t %s expected %0h got %0h", $time, sig, exp, act);
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        total_checks += test_checks;
        if (test_errors > 0) begin
            tests_failed++;
        end
        $display("%-16s %0d checks, %0d errors, %s", test_name, test_checks, test_errors,
                 (test_errors == 0) ? "ok" : "FAILED");
    endtask

    // reference pixel from the mapping and colour rules
    function automatic logic model_colour(input int h, input int v);
        int          tile;
        int          r;
        int          c;
        int          cf;
        int          sr;
        int          sc;
        int          win;
        logic [13:0] ent;
        logic [7:0]  line;
        if (h >= h_visible || v >= v_visible) begin
            return 1'b0;
        end
        tile = (v / tile_len_pixel) * screen_tiles_h + h / tile_len_pixel;
        r = (v % tile_len_pixel) / upscale;
        c = (h % tile_len_pixel) / upscale;
        win = -1;
        // first used slot on this tile wins
        for (int s = 0; s < num_slots; s++) begin
            if (win < 0 && model_slots[s][13:10] < 8 && model_slots[s][7:0] == tile) begin
                win = s;
            end
        end
        if (win < 0) begin
            return 1'b1;
        end
        ent = model_slots[win];
        cf = (win >= flip_first_slot) ? 7 - c : c;
        case (ent[9:8])
            2'd0: begin
                sr = r;
                sc = cf;
            end
            2'd1: begin
                sr = 7 - cf;
                sc = r;
            end
            2'd2: begin
                sr = 7 - r;
                sc = 7 - cf;
            end
            default: begin
                sr = cf;
                sc = 7 - r;
            end
        endcase
        line = rom_model[ent[12:10] * 8 + sr];
        return line[7 - sc];
    endfunction

    function automatic logic [15:0] random_entity(input bit used_only);
        logic [3:0] id;
        logic [1:0] orient;
        logic [7:0] tile;
        id = 4'($random(seed));
        if (used_only) begin
            id[3] = 1'b0;
        end
        orient = 2'($random(seed));
        tile = 8'($unsigned($random(seed)) % 192);
        return {2'b00, id, orient, tile};
    endfunction

    // one wishbone classic access returning read data at ack
    task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [15:0] wdata,
                             output logic [15:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (!wb_ack && waited < bus_timeout) begin
            waited++;
            @(negedge clk);
        end
        rdata = wb_dat_r;
        if (!wb_ack) begin
            test_errors++;
            $display("bus access to address %0d was never acknowledged", adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        @(negedge clk);
        // ack must be gone after one cycle
        expect_val("wb_ack", 16'd0, wb_ack);
    endtask

    task automatic write_slot(input logic [3:0] adr, input logic [15:0] data);
        logic [15:0] unused;
        bus_cycle(1'b1, adr, data, unused);
        if (adr < num_slots) begin
            model_slots[adr] = data[13:0];
        end
    endtask

    task automatic read_check(input logic [3:0] adr, input logic [15:0] exp);
        logic [15:0] rd;
        bus_cycle(1'b0, adr, 16'd0, rd);
        expect_val("wb_dat_r", exp, rd);
    endtask

    // compare pins against the model from first to last position
    task automatic check_frame(input int first, input int last);
        int h;
        int v;
        bit done;
        done = 1'b0;
        while (pos != first) begin
            @(negedge clk);
        end
        while (!done) begin
            h = pos % h_total;
            v = pos / h_total;
            expect_val("colour", model_colour(h, v), colour);
            expect_val("video_on", (h < h_visible) && (v < v_visible), video_on);
            expect_val("hsync", !(h >= 656 && h < 752), hsync);
            expect_val("vsync", !(v >= 490 && v < 492), vsync);
            if (pos == last) begin
                done = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    // watchdog
    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, run did not complete", timeout_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        seed = 58;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 4'd0;
        wb_dat_w = 16'd0;
        total_errors = 0;
        total_checks = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int i = 0; i < num_slots; i++) begin
            model_slots[i] = slot_reset_word[13:0];
        end
        $readmemb(rom_file, rom_model);
        repeat (3) @(negedge clk);

        // outputs while reset is held and then a white frame
        start_test("reset_state");
        expect_val("wb_ack", 16'd0, wb_ack);
        expect_val("video_on", 16'd0, video_on);
        expect_val("colour", 16'd0, colour);
        expect_val("hsync", 16'd1, hsync);
        expect_val("vsync", 16'd1, vsync);
        rst_n = 1'b1;
        check_frame(0, vis_end);
        for (int a = 0; a < num_slots; a++) begin
            read_check(4'(a), slot_reset_word);
        end
        finish_test();

        // writes land in vertical blanking and never touch visible pixels
        start_test("bus_round_trip");
        for (int a = 0; a < 16; a++) begin
            bus_data[a] = 16'($random(seed));
            write_slot(4'(a), bus_data[a]);
        end
        for (int a = 0; a < 16; a++) begin
            read_check(4'(a), (a < num_slots) ? {2'b00, bus_data[a][13:0]} : 16'd0);
        end
        finish_test();

        start_test("random_scene");
        for (int a = 0; a < num_slots; a++) begin
            write_slot(4'(a), random_entity(1'b0));
        end
        check_frame(0, vis_end);
        finish_test();

        // slots 2, 4 and 7 share one tile with all others unused
        start_test("priority");
        prio_tile = 8'($unsigned($random(seed)) % 192);
        base_id = $unsigned($random(seed)) % 8;
        for (int a = 0; a < num_slots; a++) begin
            write_slot(4'(a), slot_reset_word);
        end
        write_slot(4'd7, {2'b00, 4'((base_id + 5) % 8), 2'($random(seed)), prio_tile});
        write_slot(4'd4, {2'b00, 4'((base_id + 3) % 8), 2'($random(seed)), prio_tile});
        write_slot(4'd2, {2'b00, 4'(base_id), 2'($random(seed)), prio_tile});
        check_frame(0, vis_end);
        finish_test();

        start_test("frame_update");
        slot = $unsigned($random(seed)) % num_slots;
        write_slot(4'(slot), random_entity(1'b1));
        check_frame(0, vis_end);
        finish_test();

        // full frame incl. vertical sync pulse
        start_test("sync_timing");
        check_frame(0, frame_cycles - 1);
        finish_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/sprite_renderer_top.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_renderer_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [sprite_pkg::wb_adr_width-1:0] wb_adr,
    input  logic [sprite_pkg::wb_dat_width-1:0] wb_dat_w,
    output logic [sprite_pkg::wb_dat_width-1:0] wb_dat_r,
    output logic                                wb_ack,
    output logic                                colour,
    output logic                                hsync,
    output logic                                vsync,
    output logic                                video_on
);

    import sprite_pkg::*;

    logic [num_slots*entity_width-1:0] slot_bus;
    // raw scan signals, stage 0
    logic [9:0] counter_h;
    logic [9:0] counter_v;
    logic       hsync_raw;
    logic       vsync_raw;
    logic       video_on_raw;
    // detect stage outputs
    logic       hit;
    logic [2:0] sprite_id;
    logic [2:0] src_row;
    logic [2:0] src_col;
    logic       hsync_d;
    logic       vsync_d;
    logic       video_on_d;

    entity_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .slot_bus (slot_bus)
    );

    scan_timing u_timing (
        .clk       (clk),
        .rst_n     (rst_n),
        .counter_h (counter_h),
        .counter_v (counter_v),
        .hsync     (hsync_raw),
        .vsync     (vsync_raw),
        .video_on  (video_on_raw)
    );

    entity_detect u_detect (
        .clk        (clk),
        .rst_n      (rst_n),
        .slot_bus   (slot_bus),
        .counter_h  (counter_h),
        .counter_v  (counter_v),
        .hsync      (hsync_raw),
        .vsync      (vsync_raw),
        .video_on   (video_on_raw),
        .hit        (hit),
        .sprite_id  (sprite_id),
        .src_row    (src_row),
        .src_col    (src_col),
        .hsync_d    (hsync_d),
        .vsync_d    (vsync_d),
        .video_on_d (video_on_d)
    );

    // final stage drives the display pins
    sprite_rom u_rom (
        .clk          (clk),
        .rst_n        (rst_n),
        .hit          (hit),
        .sprite_id    (sprite_id),
        .src_row      (src_row),
        .src_col      (src_col),
        .hsync_d      (hsync_d),
        .vsync_d      (vsync_d),
        .video_on_d   (video_on_d),
        .colour       (colour),
        .hsync_out    (hsync),
        .vsync_out    (vsync),
        .video_on_out (video_on)
    );

endmodule

`default_nettype wire

//--- logic/sprite_rom.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_rom (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hit,
    input  logic [2:0] sprite_id,
    input  logic [2:0] src_row,
    input  logic [2:0] src_col,
    input  logic       hsync_d,
    input  logic       vsync_d,
    input  logic       video_on_d,
    output logic       colour,
    output logic       hsync_out,
    output logic       vsync_out,
    output logic       video_on_out
);

    import sprite_pkg::*;

    // 8 lines of 8 bits per sprite
    logic [sprite_size-1:0] rom [rom_depth];
    logic [5:0]             rom_addr;
    logic [sprite_size-1:0] rom_line;
    logic                   pix_bit;
    logic                   colour_n;

    initial begin
        $readmemb(rom_file, rom);
    end

    // line 8*id + row
    assign rom_addr = {sprite_id, src_row};
    assign rom_line = rom[rom_addr];
    // msb holds column 0
    assign pix_bit = rom_line[cell_max - src_col];

    // 1 white, 0 black
    always_comb begin
        if (!video_on_d) begin
            colour_n = 1'b0;
        end else if (hit) begin
            colour_n = pix_bit;
        end else begin
            // empty tile shows white background
            colour_n = 1'b1;
        end
    end

    // second pipe stage, syncs kept aligned with colour
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            colour <= 1'b0;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            video_on_out <= 1'b0;
        end else begin
            colour <= colour_n;
            hsync_out <= hsync_d;
            vsync_out <= vsync_d;
            video_on_out <= video_on_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/entity_detect.sv
`timescale 1ns/1ps
`default_nettype none

module entity_detect (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic [sprite_pkg::num_slots*sprite_pkg::entity_width-1:0] slot_bus,
    input  logic [9:0]                                              counter_h,
    input  logic [9:0]                                              counter_v,
    input  logic                                                    hsync,
    input  logic                                                    vsync,
    input  logic                                                    video_on,
    output logic                                                    hit,
    output logic [2:0]                                              sprite_id,
    output logic [2:0]                                              src_row,
    output logic [2:0]                                              src_col,
    output logic                                                    hsync_d,
    output logic                                                    vsync_d,
    output logic                                                    video_on_d
);

    import sprite_pkg::*;

    logic [9:0]                pix_tile;
    logic [9:0]                off_h;
    logic [9:0]                off_v;
    logic [2:0]                cell_r;
    logic [2:0]                cell_c;
    logic [2:0]                col_f;
    logic [entity_width-1:0]   ent;
    logic [entity_width-1:0]   win_entity;
    logic [slot_idx_width-1:0] win_slot;
    logic                      found;
    logic [2:0]                row_n;
    logic [2:0]                col_n;

    // row major tile under the beam with 16 per row
    assign pix_tile = 10'((counter_v / tile_len_pixel) * screen_tiles_h
                          + counter_h / tile_len_pixel);
    assign off_h = 10'(counter_h % tile_len_pixel);
    assign off_v = 10'(counter_v % tile_len_pixel);
    // 5x5 pixel cells inside the tile
    assign cell_r = 3'(off_v / upscale);
    assign cell_c = 3'(off_h / upscale);

    // scan downwards so the lowest matching slot is kept
    always_comb begin
        found = 1'b0;
        win_slot = '0;
        win_entity = '0;
        ent = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            ent = slot_bus[i*entity_width +: entity_width];
            // ids 8..15 draw nothing
            if ((ent[id_lsb +: id_width] < id_unused_min)
                    && ({2'b00, ent[tile_lsb +: tile_width]} == pix_tile)) begin
                found = 1'b1;
                win_slot = slot_idx_width'(i);
                win_entity = ent;
            end
        end
    end

    // mirror first for the last two slots
    assign col_f = (win_slot >= flip_first_slot) ? (cell_max - cell_c) : cell_c;

    // rotation into bitmap coordinates
    always_comb begin
        case (win_entity[orient_lsb +: orient_width])
            orient_right: begin
                row_n = cell_max - col_f;
                col_n = cell_r;
            end
            orient_down: begin
                row_n = cell_max - cell_r;
                col_n = cell_max - col_f;
            end
            orient_left: begin
                row_n = col_f;
                col_n = cell_max - cell_r;
            end
            default: begin
                row_n = cell_r;
                col_n = col_f;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit <= 1'b0;
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
            video_on_d <= 1'b0;
        end else begin
            hit <= found;
            hsync_d <= hsync;
            vsync_d <= vsync;
            video_on_d <= video_on;
        end
    end

    // lookup payload only meaningful with hit
    always_ff @(posedge clk) begin
        sprite_id <= win_entity[id_lsb +: 3];
        src_row <= row_n;
        src_col <= col_n;
    end

endmodule

`default_nettype wire

//--- logic/scan_timing.sv
`timescale 1ns/1ps
`default_nettype none

module scan_timing (
    input  logic       clk,
    input  logic       rst_n,
    output logic [9:0] counter_h,
    output logic [9:0] counter_v,
    output logic       hsync,
    output logic       vsync,
    output logic       video_on
);

    import sprite_pkg::*;

    // sync pulse windows
    localparam int hs_start = h_visible + h_front;
    localparam int hs_end = hs_start + h_sync;
    localparam int vs_start = v_visible + v_front;
    localparam int vs_end = vs_start + v_sync;

    logic h_last;
    logic v_last;

    assign h_last = (counter_h == 10'(h_total - 1));
    assign v_last = (counter_v == 10'(v_total - 1));

    // pixel counter, one step per clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counter_h <= '0;
        end else if (h_last) begin
            counter_h <= '0;
        end else begin
            counter_h <= counter_h + 10'd1;
        end
    end

    // line counter moves at end of each line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counter_v <= '0;
        end else if (h_last) begin
            if (v_last) begin
                counter_v <= '0;
            end else begin
                counter_v <= counter_v + 10'd1;
            end
        end
    end

    // active low syncs straight from the counters
    assign hsync = !((counter_h >= hs_start) && (counter_h < hs_end));
    assign vsync = !((counter_v >= vs_start) && (counter_v < vs_end));
    // 640x480 window only
    assign video_on = (counter_h < h_visible) && (counter_v < v_visible);

endmodule

`default_nettype wire

//--- logic/entity_regs.sv
`timescale 1ns/1ps
`default_nettype none

module entity_regs (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    wb_cyc,
    input  logic                                                    wb_stb,
    input  logic                                                    wb_we,
    input  logic [sprite_pkg::wb_adr_width-1:0]                     wb_adr,
    input  logic [sprite_pkg::wb_dat_width-1:0]                     wb_dat_w,
    output logic [sprite_pkg::wb_dat_width-1:0]                     wb_dat_r,
    output logic                                                    wb_ack,
    output logic [sprite_pkg::num_slots*sprite_pkg::entity_width-1:0] slot_bus
);

    import sprite_pkg::*;

    // one register per entity slot
    logic [entity_width-1:0] slots [num_slots];
    // new request seen this cycle, not yet acked
    logic                    req;
    logic                    adr_valid;

    assign req = wb_cyc && wb_stb && !wb_ack;
    // addresses 9..15 are holes in the map
    assign adr_valid = (wb_adr < num_slots);

    // single cycle ack, drops even while stb is still held
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // slot writes land with the ack edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_slots; i++) begin
                // unused id, orientation up, tile 0
                slots[i] <= {id_reset, orient_up, {tile_width{1'b0}}};
            end
        end else if (req && wb_we && adr_valid) begin
            for (int i = 0; i < num_slots; i++) begin
                if (wb_adr == i) begin
                    // upper data bits are dropped
                    slots[i] <= wb_dat_w[entity_width-1:0];
                end
            end
        end
    end

    // read mux, zero for holes
    always_comb begin
        wb_dat_r = '0;
        for (int i = 0; i < num_slots; i++) begin
            if (wb_adr == i) begin
                wb_dat_r = {{(wb_dat_width - entity_width){1'b0}}, slots[i]};
            end
        end
    end

    // flatten, slot 0 in the low bits
    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            slot_bus[i*entity_width +: entity_width] = slots[i];
        end
    end

endmodule

`default_nettype wire

//--- logic/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

    // screen grid
    localparam int screen_tiles_h = 16;
    localparam int screen_tiles_v = 12;
    localparam int tile_len_pixel = 40;
    localparam int upscale = 5;
    localparam int sprite_size = 8;
    // largest cell index inside a tile, used for mirroring
    localparam logic [2:0] cell_max = 3'(sprite_size - 1);

    // entity word layout: id, orientation, tile
    localparam int num_slots = 9;
    localparam int slot_idx_width = $clog2(num_slots);
    localparam int flip_first_slot = 7;
    localparam int entity_width = 14;
    localparam int id_lsb = 10;
    localparam int id_width = 4;
    localparam int orient_lsb = 8;
    localparam int orient_width = 2;
    localparam int tile_lsb = 0;
    localparam int tile_width = 8;
    localparam int id_unused_min = 8;
    localparam logic [3:0] id_reset = 4'd15;

    localparam logic [1:0] orient_up = 2'd0;
    localparam logic [1:0] orient_right = 2'd1;
    localparam logic [1:0] orient_down = 2'd2;
    localparam logic [1:0] orient_left = 2'd3;

    // 800x525 scan, visible part derived from the tile grid
    localparam int h_visible = screen_tiles_h * tile_len_pixel;
    localparam int h_front = 16;
    localparam int h_sync = 96;
    localparam int h_back = 48;
    localparam int v_visible = screen_tiles_v * tile_len_pixel;
    localparam int v_front = 10;
    localparam int v_sync = 2;
    localparam int v_back = 33;
    localparam int h_total = h_visible + h_front + h_sync + h_back;
    localparam int v_total = v_visible + v_front + v_sync + v_back;

    // sprite bitmaps, eight lines per usable id
    localparam int rom_depth = id_unused_min * sprite_size;
    localparam rom_file = "logic/sprite_rom.mem";
    localparam int pipe_latency = 2;

    // wishbone register map, one word per slot
    localparam int wb_adr_width = 4;
    localparam int wb_dat_width = 16;

endpackage

`default_nettype wire
